// ==== logic/cpu_settings.svh ====
// width and size macros for the core, included by the package and by RTL blocks that size storage
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width
`define CPU_XLEN 32

// architectural registers and the bits to select one
`define CPU_NREGS 16
`define CPU_REGW 4

// instruction fields
`define CPU_OPW 4
`define CPU_IMMW 16

// dispatch queue entries and pointer width
`define SB_DEPTH 4
`define SB_PTRW 2

`endif

// ==== logic/pipeline_pkg.sv ====
// shared vector types, opcode and fetch state enums and decode helpers for the core and testbench
`default_nettype none

`include "cpu_settings.svh"

package pipeline_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_XLEN-1:0] instr_t;
    typedef logic [`CPU_REGW-1:0] regsel_t;
    typedef logic [`CPU_IMMW-1:0] imm_t;

    // unlisted codes decode as no-ops
    typedef enum logic [`CPU_OPW-1:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        ADDI = 4'h6,
        BEQ  = 4'h7,
        HALT = 4'h8
    } opcode_t;

    // stopped once a halt has been fetched
    typedef enum logic {
        RUN,
        STOPPED
    } fetch_state_t;

    // field layout op[31:28] rd[27:24] rs1[23:20] rs2[19:16] imm[15:0]
    function automatic opcode_t instr_op(instr_t i);
        return opcode_t'(i[31:28]);
    endfunction

    function automatic regsel_t instr_rd(instr_t i);
        return i[27:24];
    endfunction

    function automatic regsel_t instr_rs1(instr_t i);
        return i[23:20];
    endfunction

    function automatic regsel_t instr_rs2(instr_t i);
        return i[19:16];
    endfunction

    function automatic word_t instr_imm(instr_t i);
        imm_t imm;
        imm = i[`CPU_IMMW-1:0];
        return word_t'(signed'(imm));
    endfunction

    // register operand usage per opcode
    function automatic logic uses_rs1(opcode_t op);
        return op inside {ADD, SUB, AND, OR, XOR, ADDI, BEQ};
    endfunction

    function automatic logic uses_rs2(opcode_t op);
        return op inside {ADD, SUB, AND, OR, XOR, BEQ};
    endfunction

    // r0 writes are dropped here so no busy bit or writeback is produced
    function automatic logic writes_rd(opcode_t op, regsel_t rd);
        return (op inside {ADD, SUB, AND, OR, XOR, ADDI}) && (rd != '0);
    endfunction

endpackage

`default_nettype wire

// ==== logic/fetch.sv ====
// fetch stage with pc, run/stop fsm, instruction memory request and fetch/dispatch latch
`timescale 1ns/10ps
`default_nettype none

module fetch import pipeline_pkg::*; (
    input  logic   CLK,
    input  logic   nrst,
    input  logic   ihit,
    input  instr_t imemload,
    input  logic   dispatch_free,
    input  logic   misprediction,
    input  word_t  correct_target,
    output word_t  imemaddr,
    output logic   iren,
    output logic   fd_valid,
    output instr_t fd_instr,
    output word_t  fd_pc
);

    word_t        pc;
    fetch_state_t state;
    logic         fetch_hit;

    // request only while running and the queue has room
    // a redirect drops the request so memory abandons the old address
    assign iren      = (state == RUN) && dispatch_free && !misprediction;
    assign imemaddr  = pc;
    assign fetch_hit = iren && ihit;

    // pc and fsm
    // branches always predicted not taken so the pc just steps by 4
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc       <= '0;
            state    <= RUN;
            fd_valid <= 1'b0;
        end else if (misprediction) begin
            // redirect wins over any hit and restarts a stopped fetch
            pc       <= correct_target;
            state    <= RUN;
            fd_valid <= 1'b0;
        end else begin
            fd_valid <= fetch_hit;
            if (fetch_hit) begin
                pc <= pc + word_t'(4);
                if (instr_op(imemload) == HALT) begin
                    state <= STOPPED;
                end
            end
        end
    end

    // fetch/dispatch latch payload
    always_ff @(posedge CLK) begin
        if (fetch_hit) begin
            fd_instr <= imemload;
            fd_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/scoreboard.sv ====
// dispatch queue with per-register busy bits, in-order issue of the head and flush on redirect
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module scoreboard import pipeline_pkg::*; (
    input  logic    CLK,
    input  logic    nrst,
    input  logic    fd_valid,
    input  instr_t  fd_instr,
    input  word_t   fd_pc,
    input  logic    misprediction,
    input  logic    wb_en,
    input  regsel_t wb_sel,
    output logic    dispatch_free,
    output logic    issue_valid,
    output instr_t  issue_instr,
    output word_t   issue_pc
);

    // queue storage
    instr_t q_instr [`SB_DEPTH];
    word_t  q_pc    [`SB_DEPTH];

    logic [`SB_PTRW-1:0] head;
    logic [`SB_PTRW-1:0] tail;
    logic [`SB_PTRW:0]   count;

    // one bit per architectural register
    logic [`CPU_NREGS-1:0] busy;
    logic [`CPU_NREGS-1:0] busy_next;

    logic    push;
    opcode_t head_op;
    regsel_t head_rd;
    logic    src1_ready;
    logic    src2_ready;
    logic    dst_ready;
    logic    head_writes;

    // wrong-path fetches arriving with a redirect are dropped
    assign push = fd_valid && !misprediction;

    // two free entries leave room for the fetch already in flight
    assign dispatch_free = int'(count) <= `SB_DEPTH - 2;

    // head decode
    assign issue_instr = q_instr[head];
    assign issue_pc    = q_pc[head];
    assign head_op     = instr_op(issue_instr);
    assign head_rd     = instr_rd(issue_instr);
    assign head_writes = writes_rd(head_op, head_rd);

    // r0 is never set busy so it always reads as ready
    assign src1_ready = !uses_rs1(head_op) || !busy[instr_rs1(issue_instr)];
    assign src2_ready = !uses_rs2(head_op) || !busy[instr_rs2(issue_instr)];

    // also wait on a pending write to rd
    // otherwise an older writeback could clear the bit of a younger producer
    assign dst_ready = !head_writes || !busy[head_rd];

    assign issue_valid = (count != '0) && !misprediction
                         && src1_ready && src2_ready && dst_ready;

    // busy bits
    // writeback clears at the end of its cycle, a new issue sets last
    always_comb begin
        busy_next = busy;
        if (wb_en) begin
            busy_next[wb_sel] = 1'b0;
        end
        if (issue_valid && head_writes) begin
            busy_next[head_rd] = 1'b1;
        end
    end

    // in-flight producers keep their busy bits across a flush
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // pointers and occupancy
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (misprediction) begin
            // flush everything behind the branch
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (issue_valid) begin
                head <= head + 1'b1;
            end
            case ({push, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge CLK) begin
        if (push) begin
            q_instr[tail] <= fd_instr;
            q_pc[tail]    <= fd_pc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
// register file with two asynchronous read ports and one write port, r0 hardwired to zero
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module regfile import pipeline_pkg::*; (
    input  logic    CLK,
    input  logic    nrst,
    input  logic    wen,
    input  regsel_t wsel,
    input  word_t   wdat,
    input  regsel_t rsel1,
    input  regsel_t rsel2,
    output word_t   rdat1,
    output word_t   rdat2
);

    word_t regs [`CPU_NREGS];

    // whole file cleared at reset
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdat;
        end
    end

    // no write bypass
    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
// execute stage with operand read, alu, branch resolution, writeback latch and halt flag
`timescale 1ns/10ps
`default_nettype none

module execute import pipeline_pkg::*; (
    input  logic    CLK,
    input  logic    nrst,
    input  logic    issue_valid,
    input  instr_t  issue_instr,
    input  word_t   issue_pc,
    output logic    misprediction,
    output word_t   correct_target,
    output logic    wb_en,
    output regsel_t wb_sel,
    output word_t   wb_data,
    output logic    halt
);

    // register file read data at issue
    word_t rdat1;
    word_t rdat2;

    // issue/execute latch
    logic    ie_valid;
    opcode_t ie_op;
    regsel_t ie_rd;
    word_t   ie_a;
    word_t   ie_b;
    word_t   ie_imm;
    word_t   ie_pc;

    word_t alu_out;

    regfile i_regfile (
        .CLK   (CLK),
        .nrst  (nrst),
        .wen   (wb_en),
        .wsel  (wb_sel),
        .wdat  (wb_data),
        .rsel1 (instr_rs1(issue_instr)),
        .rsel2 (instr_rs2(issue_instr)),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    // operands captured at issue
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ie_valid <= 1'b0;
        end else begin
            ie_valid <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            ie_op  <= instr_op(issue_instr);
            ie_rd  <= instr_rd(issue_instr);
            ie_a   <= rdat1;
            ie_b   <= rdat2;
            ie_imm <= instr_imm(issue_instr);
            ie_pc  <= issue_pc;
        end
    end

    // alu
    always_comb begin
        case (ie_op)
            ADD:     alu_out = ie_a + ie_b;
            SUB:     alu_out = ie_a - ie_b;
            AND:     alu_out = ie_a & ie_b;
            OR:      alu_out = ie_a | ie_b;
            XOR:     alu_out = ie_a ^ ie_b;
            ADDI:    alu_out = ie_a + ie_imm;
            default: alu_out = '0;
        endcase
    end

    // taken beq is the only redirect
    // immediate counts words from the next sequential pc
    assign misprediction  = ie_valid && (ie_op == BEQ) && (ie_a == ie_b);
    assign correct_target = ie_pc + word_t'(4) + (ie_imm << 2);

    // execute/writeback latch
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_en <= 1'b0;
            halt  <= 1'b0;
        end else begin
            wb_en <= ie_valid && writes_rd(ie_op, ie_rd);
            // sticky until reset
            if (ie_valid && (ie_op == HALT)) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        wb_sel  <= ie_rd;
        wb_data <= alu_out;
    end

endmodule

`default_nettype wire

// ==== logic/sc_datapath.sv ====
// core top connecting fetch, scoreboard and execute to the instruction memory port
`timescale 1ns/10ps
`default_nettype none

module sc_datapath import pipeline_pkg::*; (
    input  logic    CLK,
    input  logic    nrst,
    input  instr_t  imemload,
    input  logic    ihit,
    output word_t   imemaddr,
    output logic    iren,
    output logic    wb_en,
    output regsel_t wb_sel,
    output word_t   wb_data,
    output logic    halt
);

    // fetch to scoreboard
    logic   fd_valid;
    instr_t fd_instr;
    word_t  fd_pc;
    logic   dispatch_free;

    // scoreboard to execute
    logic   issue_valid;
    instr_t issue_instr;
    word_t  issue_pc;

    // redirect from execute
    logic   misprediction;
    word_t  correct_target;

    fetch i_fetch (
        .CLK            (CLK),
        .nrst           (nrst),
        .ihit           (ihit),
        .imemload       (imemload),
        .dispatch_free  (dispatch_free),
        .misprediction  (misprediction),
        .correct_target (correct_target),
        .imemaddr       (imemaddr),
        .iren           (iren),
        .fd_valid       (fd_valid),
        .fd_instr       (fd_instr),
        .fd_pc          (fd_pc)
    );

    // writeback strobe also releases busy registers
    scoreboard i_scoreboard (
        .CLK           (CLK),
        .nrst          (nrst),
        .fd_valid      (fd_valid),
        .fd_instr      (fd_instr),
        .fd_pc         (fd_pc),
        .misprediction (misprediction),
        .wb_en         (wb_en),
        .wb_sel        (wb_sel),
        .dispatch_free (dispatch_free),
        .issue_valid   (issue_valid),
        .issue_instr   (issue_instr),
        .issue_pc      (issue_pc)
    );

    execute i_execute (
        .CLK            (CLK),
        .nrst           (nrst),
        .issue_valid    (issue_valid),
        .issue_instr    (issue_instr),
        .issue_pc       (issue_pc),
        .misprediction  (misprediction),
        .correct_target (correct_target),
        .wb_en          (wb_en),
        .wb_sel         (wb_sel),
        .wb_data        (wb_data),
        .halt           (halt)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_sc_datapath.sv ====
// self-checking testbench that runs small programs on the core against an instruction model
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module tb_sc_datapath import pipeline_pkg::*; ();

    localparam int MEM_WORDS = 64;

    // dut ports
    logic    CLK;
    logic    nrst;
    instr_t  imemload;
    logic    ihit;
    word_t   imemaddr;
    logic    iren;
    logic    wb_en;
    regsel_t wb_sel;
    word_t   wb_data;
    logic    halt;

    // program image and memory model state
    instr_t prog [MEM_WORDS];
    integer seed = 32'hd6e4e283;
    logic   pending;
    word_t  req_addr;
    int     wait_left;

    // expected writebacks and register images
    regsel_t exp_sel [$];
    word_t   exp_val [$];
    word_t   model_regs [`CPU_NREGS];
    word_t   seen_regs [`CPU_NREGS];
    int      model_steps;
    logic    halt_seen;

    // bookkeeping
    int    errors;
    int    passed;
    int    failed;
    int    cycles;
    int    budget = 1000;
    string cur_test;

    sc_datapath i_sc_datapath (
        .CLK      (CLK),
        .nrst     (nrst),
        .imemload (imemload),
        .ihit     (ihit),
        .imemaddr (imemaddr),
        .iren     (iren),
        .wb_en    (wb_en),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .halt     (halt)
    );

    always #10 CLK = ~CLK;

    // op rd rs1 rs2 imm
    function automatic instr_t encode(opcode_t op, int rd, int rs1, int rs2, int imm);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)};
    endfunction

    // instruction memory answers after 0 to 3 wait cycles
    // a dropped iren abandons the request
    always @(negedge CLK) begin
        ihit = 1'b0;
        if (!nrst || !iren) begin
            pending = 1'b0;
        end else begin
            if (!pending || (imemaddr != req_addr)) begin
                pending   = 1'b1;
                req_addr  = imemaddr;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                ihit     = 1'b1;
                imemload = prog[imemaddr[7:2]];
                pending  = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // writebacks follow the model in order and stop at halt
    always @(posedge CLK) begin
        if (nrst) begin
            if (wb_en) begin
                assert (!halt_seen) else begin
                    errors++;
                    $display("writeback to r%0d arrived after halt", wb_sel);
                end
                assert (exp_sel.size() > 0) else begin
                    errors++;
                    $display("writeback to r%0d arrived with none expected", wb_sel);
                end
                if (exp_sel.size() > 0) begin
                    assert (wb_sel == exp_sel[0]) else begin
                        errors++;
                        $display("[ERROR] wb_sel expected 0x%h got 0x%h", exp_sel[0], wb_sel);
                    end
                    assert (wb_data == exp_val[0]) else begin
                        errors++;
                        $display("[ERROR] wb_data expected 0x%h got 0x%h", exp_val[0], wb_data);
                    end
                    void'(exp_sel.pop_front());
                    void'(exp_val.pop_front());
                end
                seen_regs[wb_sel] = wb_data;
            end
            // halt must trail the last expected result
            if (halt && !halt_seen) begin
                assert (exp_sel.size() == 0) else begin
                    errors++;
                    $display("halt raised with %0d writebacks outstanding", exp_sel.size());
                end
                halt_seen = 1'b1;
            end
        end
    end

    // per-test cycle budget
    initial begin
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge CLK);
            if (nrst) begin
                cycles++;
            end
        end
        $display("watchdog expired after %0d cycles in test %s", cycles, cur_test);
        $display("STATUS: FAIL");
        $finish;
    end

    // unused words decode as no-ops and carry their own index
    task automatic load_program(input int id);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = {4'hF, 28'(i)};
        end
        case (id)
            0: begin
                prog[0]  = encode(ADDI, 1, 0, 0, 5);
                prog[1]  = encode(ADDI, 2, 0, 0, -3);
                prog[2]  = encode(ADDI, 3, 0, 0, 'h1234);
                prog[3]  = encode(ADDI, 4, 0, 0, 'h0f0f);
                prog[4]  = encode(ADDI, 10, 0, 0, 'h8000);
                prog[5]  = encode(ADD, 5, 1, 2, 0);
                prog[6]  = encode(SUB, 6, 1, 2, 0);
                prog[7]  = encode(AND, 7, 3, 4, 0);
                prog[8]  = encode(OR, 8, 3, 4, 0);
                prog[9]  = encode(XOR, 9, 3, 4, 0);
                prog[10] = encode(HALT, 0, 0, 0, 0);
            end
            1: begin
                // serial chain where each instruction waits on the one before
                // slow issue lets fetch fill the queue
                prog[0] = encode(ADDI, 1, 0, 0, 1);
                for (int k = 0; k < 12; k++) begin
                    prog[1 + 3 * k] = encode(ADD, 1, 1, 3, 0);
                    prog[2 + 3 * k] = encode(ADDI, 2, 1, 0, k);
                    prog[3 + 3 * k] = encode(XOR, 3, 3, 2, 0);
                end
                prog[37] = encode(HALT, 0, 0, 0, 0);
            end
            2: begin
                prog[0]  = encode(ADDI, 1, 0, 0, 7);
                prog[1]  = encode(ADDI, 2, 0, 0, 7);
                prog[2]  = encode(BEQ, 0, 1, 2, 2);
                prog[3]  = encode(ADDI, 3, 0, 0, 1);
                prog[4]  = encode(ADDI, 4, 0, 0, 2);
                prog[5]  = encode(ADDI, 5, 0, 0, 3);
                prog[6]  = encode(BEQ, 0, 1, 5, 1);
                prog[7]  = encode(ADDI, 6, 0, 0, 4);
                // three-pass loop with a backward branch
                prog[8]  = encode(ADDI, 7, 0, 0, 3);
                prog[9]  = encode(ADDI, 7, 7, 0, -1);
                prog[10] = encode(ADDI, 8, 8, 0, 5);
                prog[11] = encode(BEQ, 0, 7, 0, 1);
                prog[12] = encode(BEQ, 0, 0, 0, -4);
                prog[13] = encode(HALT, 0, 0, 0, 0);
            end
            default: begin
                prog[0] = encode(ADDI, 0, 0, 0, 9);
                prog[1] = encode(ADDI, 1, 0, 0, 11);
                prog[2] = encode(ADD, 0, 1, 1, 0);
                prog[3] = encode(ADD, 2, 0, 1, 0);
                prog[4] = encode(XOR, 3, 1, 0, 0);
                prog[5] = encode(BEQ, 0, 0, 0, 1);
                prog[6] = encode(HALT, 0, 0, 0, 0);
                prog[7] = encode(NOP, 9, 9, 9, 0);
                prog[8] = encode(ADDI, 4, 2, 0, 1);
                prog[9] = encode(HALT, 0, 0, 0, 0);
            end
        endcase
    endtask

    // architectural interpreter of the loaded program
    task automatic compute_expected();
        word_t   pc;
        instr_t  ins;
        opcode_t op;
        regsel_t rd;
        regsel_t rs1;
        regsel_t rs2;
        word_t   imm;
        word_t   val;
        logic    wr;
        logic    done;
        exp_sel.delete();
        exp_val.delete();
        for (int i = 0; i < `CPU_NREGS; i++) begin
            model_regs[i] = '0;
        end
        pc          = '0;
        done        = 1'b0;
        model_steps = 0;
        while (!done && (model_steps < 2000)) begin
            ins = prog[pc[7:2]];
            op  = opcode_t'(ins[31:28]);
            rd  = ins[27:24];
            rs1 = ins[23:20];
            rs2 = ins[19:16];
            imm = {{16{ins[15]}}, ins[15:0]};
            wr  = 1'b1;
            val = '0;
            case (op)
                ADD:     val = model_regs[rs1] + model_regs[rs2];
                SUB:     val = model_regs[rs1] - model_regs[rs2];
                AND:     val = model_regs[rs1] & model_regs[rs2];
                OR:      val = model_regs[rs1] | model_regs[rs2];
                XOR:     val = model_regs[rs1] ^ model_regs[rs2];
                ADDI:    val = model_regs[rs1] + imm;
                default: wr = 1'b0;
            endcase
            pc = pc + 32'd4;
            if ((op == BEQ) && (model_regs[rs1] == model_regs[rs2])) begin
                pc = pc + (imm << 2);
            end
            done = (op == HALT);
            // r0 stays zero and makes no writeback
            if (wr && (rd != '0)) begin
                model_regs[rd] = val;
                exp_sel.push_back(rd);
                exp_val.push_back(val);
            end
            model_steps++;
        end
    endtask

    task automatic run_test(input int id, input string name);
        int errors_before;
        errors_before = errors;
        cur_test      = name;
        @(negedge CLK);
        nrst <= 1'b0;
        load_program(id);
        compute_expected();
        halt_seen = 1'b0;
        for (int r = 0; r < `CPU_NREGS; r++) begin
            seen_regs[r] = '0;
        end
        budget = 40 * model_steps + 200;
        repeat (10) @(negedge CLK);
        // reset values while memory is still idle
        assert (!wb_en) else begin
            errors++;
            $display("[ERROR] wb_en expected 0x0 got 0x%h", wb_en);
        end
        assert (!halt) else begin
            errors++;
            $display("[ERROR] halt expected 0x0 got 0x%h", halt);
        end
        assert (imemaddr == '0) else begin
            errors++;
            $display("[ERROR] imemaddr expected 0x00000000 got 0x%h", imemaddr);
        end
        assert (iren) else begin
            errors++;
            $display("[ERROR] iren expected 0x1 got 0x%h", iren);
        end
        cycles = 0;
        nrst  <= 1'b1;
        while (!halt) begin
            @(negedge CLK);
        end
        // quiet period for stray writebacks
        repeat (20) @(negedge CLK);
        assert (exp_sel.size() == 0) else begin
            errors++;
            $display("%0d expected writebacks never arrived", exp_sel.size());
        end
        for (int r = 0; r < `CPU_NREGS; r++) begin
            assert (seen_regs[r] == model_regs[r]) else begin
                errors++;
                $display("[ERROR] r%0d expected 0x%h got 0x%h", r, model_regs[r], seen_regs[r]);
            end
        end
        if (errors == errors_before) begin
            passed++;
            $display("test %s passed after %0d cycles", name, cycles);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        CLK      = 1'b0;
        nrst     = 1'b0;
        ihit     = 1'b0;
        imemload = '0;
        errors   = 0;
        passed   = 0;
        failed   = 0;
        run_test(0, "alu_results");
        run_test(1, "dependent_chains");
        run_test(2, "branches");
        run_test(3, "r0_and_halt");
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if ((errors == 0) && (failed == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/pipeline_pkg.sv
logic/fetch.sv
logic/scoreboard.sv
logic/regfile.sv
logic/execute.sv
logic/sc_datapath.sv
testbench/tb_sc_datapath.sv

// ==== Makefile ====
# Verilator build, run and lint for the sc_datapath core

TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP      := tb_sc_datapath
LINT_TOP := sc_datapath
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
